//--- aluPkg.sv
`default_nettype none

package aluPkg;

    localparam int DataWidth = 32;  // Default word width for all modules

    typedef logic [DataWidth-1:0] aluWord_t;

    // Function codes of the integer and logic half of the ALU
    typedef enum logic [5:0] {
        IntAdd          = 6'd0,
        IntSub          = 6'd1,
        IntMul          = 6'd2,
        IntSqrt         = 6'd3,
        IntDiv          = 6'd4,
        IntMod          = 6'd5,
        ShiftLeftArith  = 6'd6,
        ShiftRightArith = 6'd7,
        CmpEq           = 6'd8,
        CmpNe           = 6'd9,
        CmpGt           = 6'd10,
        CmpLt           = 6'd11,
        CmpGtu          = 6'd12,
        CmpLtu          = 6'd13,
        LogicNot        = 6'd16,
        LogicAnd        = 6'd17,
        LogicOr         = 6'd18,
        LogicXor        = 6'd19,
        LogicXnor       = 6'd20,
        ShiftLeftLogic  = 6'd22,
        ShiftRightLogic = 6'd23
    } aluOp_t;

    typedef struct packed {
        logic divByZero;   // Bit 1
        logic zeroResult;  // Bit 0
    } aluStatus_t;

    // Wishbone register map
    typedef enum logic [1:0] {
        RegOperandA = 2'd0,
        RegOperandB = 2'd1,
        RegCommand  = 2'd2,
        RegResult   = 2'd3
    } aluReg_t;

endpackage

`default_nettype wire

//--- aluCmdIf.sv
`timescale 1ns/10ps
`default_nettype none

interface aluCmdIf import aluPkg::*; ();

    logic     start;     // One-cycle command strobe
    aluOp_t   opcode;
    aluWord_t operandA;
    aluWord_t operandB;
    logic     busy;      // Multi-cycle op still running

    // Bus side
    modport issuer (
        output start,
        output opcode,
        output operandA,
        output operandB,
        input  busy
    );

    // Arithmetic side
    modport core (
        input  start,
        input  opcode,
        input  operandA,
        input  operandB,
        output busy
    );

endinterface

`default_nettype wire

//--- intDivider.sv
`timescale 1ns/10ps
`default_nettype none

module intDivider import aluPkg::*; #(
    parameter int Width = DataWidth
) (
    input  wire              i_clock,
    input  wire              i_startSignal,
    input  wire              i_start,
    input  wire  [Width-1:0] i_dividend,
    input  wire  [Width-1:0] i_divisor,
    output logic             o_done,
    output logic [Width-1:0] o_quotient,
    output logic [Width-1:0] o_remainder,
    output logic             o_divByZero
);

    localparam int CountW = $clog2(Width);

    typedef enum logic [1:0] {Idle, Run, Fix} divState_t;

    divState_t         state;
    logic [CountW-1:0] count;
    logic [Width-1:0]  remReg;
    logic [Width-1:0]  quoReg;       // Dividend bits shift out, quotient bits shift in
    logic [Width-1:0]  divisorMag;
    logic              negQuo;
    logic              negRem;
    logic              divZero;
    logic [Width:0]    trial;
    logic [Width:0]    diff;

    assign trial = {remReg, quoReg[Width-1]};
    assign diff  = trial - {1'b0, divisorMag};

    always_ff @(posedge i_clock or posedge i_startSignal) begin
        if (i_startSignal) begin
            state <= Idle;
            count <= '0;
        end else begin
            case (state)
                Idle: if (i_start) begin
                    state <= Run;
                    count <= CountW'(Width - 1);
                end
                Run: begin
                    if (count == '0) state <= Fix;
                    count <= count - 1'b1;
                end
                default: state <= Idle;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (state == Idle && i_start) begin
            remReg     <= '0;
            quoReg     <= i_dividend[Width-1] ? -i_dividend : i_dividend;
            divisorMag <= i_divisor[Width-1] ? -i_divisor : i_divisor;
            negQuo     <= i_dividend[Width-1] ^ i_divisor[Width-1];
            negRem     <= i_dividend[Width-1];  // Remainder follows dividend sign
            divZero    <= (i_divisor == '0);
        end else if (state == Run) begin
            remReg <= diff[Width] ? trial[Width-1:0] : diff[Width-1:0];  // Restore on borrow
            quoReg <= {quoReg[Width-2:0], ~diff[Width]};
        end
    end

    // Sign fixing step
    assign o_done      = (state == Fix);
    assign o_quotient  = divZero ? '1 : (negQuo ? -quoReg : quoReg);
    assign o_remainder = negRem ? -remReg : remReg;
    assign o_divByZero = divZero;

endmodule

`default_nettype wire

//--- intSqrt.sv
`timescale 1ns/10ps
`default_nettype none

module intSqrt import aluPkg::*; #(
    parameter int Width = DataWidth
) (
    input  wire                i_clock,
    input  wire                i_startSignal,
    input  wire                i_start,
    input  wire  [Width-1:0]   i_radicand,
    output logic               o_done,
    output logic [Width/2-1:0] o_root
);

    localparam int RootW  = Width / 2;
    localparam int RemW   = RootW + 2;
    localparam int CountW = $clog2(RootW);

    typedef enum logic [1:0] {Idle, Run, Finish} sqrtState_t;

    sqrtState_t        state;
    logic [CountW-1:0] count;
    logic [Width-1:0]  radReg;
    logic [RootW-1:0]  rootReg;
    logic [RemW-1:0]   remReg;
    logic [RemW-1:0]   shifted;
    logic [RemW:0]     diff;

    // Bring down the next two radicand bits and try 4*root+1
    assign shifted = {remReg[RemW-3:0], radReg[Width-1 -: 2]};
    assign diff    = {1'b0, shifted} - {1'b0, rootReg, 2'b01};

    always_ff @(posedge i_clock or posedge i_startSignal) begin
        if (i_startSignal) begin
            state <= Idle;
            count <= '0;
        end else begin
            case (state)
                Idle: if (i_start) begin
                    state <= Run;
                    count <= CountW'(RootW - 1);
                end
                Run: begin
                    if (count == '0) state <= Finish;
                    count <= count - 1'b1;
                end
                default: state <= Idle;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (state == Idle && i_start) begin
            radReg  <= i_radicand;
            rootReg <= '0;
            remReg  <= '0;
        end else if (state == Run) begin
            radReg  <= radReg << 2;
            rootReg <= {rootReg[RootW-2:0], ~diff[RemW]};  // Root bit set when trial fits
            remReg  <= diff[RemW] ? shifted : diff[RemW-1:0];
        end
    end

    assign o_done = (state == Finish);
    assign o_root = rootReg;

endmodule

`default_nettype wire

//--- wbCmdPort.sv
`timescale 1ns/10ps
`default_nettype none

module wbCmdPort import aluPkg::*; #(
    parameter int DataWidth = aluPkg::DataWidth
) (
    input  wire                  i_clock,
    input  wire                  i_startSignal,
    input  wire                  i_wbCyc,
    input  wire                  i_wbStb,
    input  wire                  i_wbWe,
    input  wire aluReg_t         i_wbAdr,
    input  wire  [DataWidth-1:0] i_wbDat,
    output logic [DataWidth-1:0] o_wbDat,
    output logic                 o_wbAck,
    input  wire                  i_done,
    input  wire  [DataWidth-1:0] i_result,
    input  wire aluStatus_t      i_status,
    aluCmdIf.issuer              cmd
);

    typedef enum logic [1:0] {Idle, Issue, WaitDone, Ack} portState_t;

    portState_t           state;
    logic [DataWidth-1:0] operandA;
    logic [DataWidth-1:0] operandB;
    aluOp_t               opcodeReg;
    logic                 strobe;

    assign strobe  = i_wbCyc && i_wbStb;
    assign o_wbAck = (state == Ack) && strobe;  // Never acks outside a strobe

    assign cmd.start    = (state == Issue);
    assign cmd.opcode   = opcodeReg;
    assign cmd.operandA = operandA;
    assign cmd.operandB = operandB;

    // Read mux
    always_comb begin
        case (i_wbAdr)
            RegOperandA: o_wbDat = operandA;
            RegOperandB: o_wbDat = operandB;
            RegCommand:  o_wbDat = {{(DataWidth-2){1'b0}}, i_status};
            default:     o_wbDat = i_result;
        endcase
    end

    always_ff @(posedge i_clock or posedge i_startSignal) begin
        if (i_startSignal) begin
            state    <= Idle;
            operandA <= '0;
            operandB <= '0;
        end else begin
            case (state)
                Idle: begin
                    if (strobe && i_wbWe && i_wbAdr == RegCommand) begin
                        if (!cmd.busy) begin
                            opcodeReg <= aluOp_t'(i_wbDat[$bits(aluOp_t)-1:0]);
                            state     <= Issue;
                        end
                    end else if (strobe) begin
                        if (i_wbWe && i_wbAdr == RegOperandA) operandA <= i_wbDat;
                        if (i_wbWe && i_wbAdr == RegOperandB) operandB <= i_wbDat;
                        state <= Ack;
                    end
                end
                Issue:    state <= WaitDone;
                WaitDone: if (i_done) state <= Ack;  // Ack held back until result stored
                default:  if (!strobe) state <= Idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- aluCore.sv
`timescale 1ns/10ps
`default_nettype none

module aluCore import aluPkg::*; #(
    parameter int DataWidth = aluPkg::DataWidth
) (
    aluCmdIf.core                cmd,
    input  wire                  i_clock,
    input  wire                  i_startSignal,
    output logic                 o_resultValid,
    output logic [DataWidth-1:0] o_resultWord,
    output logic                 o_divByZero
);

    localparam int ShiftW = $clog2(DataWidth);

    logic [DataWidth-1:0]   singleResult;
    logic [ShiftW-1:0]      shiftAmount;
    logic [DataWidth-1:0]   divQuotient;
    logic [DataWidth-1:0]   divRemainder;
    logic [DataWidth/2-1:0] sqrtRoot;
    logic                   divDone;
    logic                   divZero;
    logic                   sqrtDone;
    logic                   divStart;
    logic                   sqrtStart;
    logic                   unitDone;
    logic                   busy;
    aluOp_t                 pendingOp;

    assign shiftAmount = cmd.operandB[ShiftW-1:0];
    assign divStart    = cmd.start && (cmd.opcode == IntDiv || cmd.opcode == IntMod);
    assign sqrtStart   = cmd.start && (cmd.opcode == IntSqrt);
    assign unitDone    = busy && (divDone || sqrtDone);
    assign cmd.busy    = busy;

    always_comb begin
        case (cmd.opcode)
            IntAdd:          singleResult = cmd.operandA + cmd.operandB;
            IntSub:          singleResult = cmd.operandA - cmd.operandB;
            IntMul:          singleResult = cmd.operandA * cmd.operandB;  // Low word
            ShiftLeftArith,
            ShiftLeftLogic:  singleResult = cmd.operandA << shiftAmount;
            ShiftRightArith: singleResult = $signed(cmd.operandA) >>> shiftAmount;
            ShiftRightLogic: singleResult = cmd.operandA >> shiftAmount;
            CmpEq:           singleResult = DataWidth'(cmd.operandA == cmd.operandB);
            CmpNe:           singleResult = DataWidth'(cmd.operandA != cmd.operandB);
            CmpGt:  singleResult = DataWidth'($signed(cmd.operandA) > $signed(cmd.operandB));
            CmpLt:  singleResult = DataWidth'($signed(cmd.operandA) < $signed(cmd.operandB));
            CmpGtu:          singleResult = DataWidth'(cmd.operandA > cmd.operandB);
            CmpLtu:          singleResult = DataWidth'(cmd.operandA < cmd.operandB);
            LogicNot:        singleResult = ~cmd.operandA;
            LogicAnd:        singleResult = cmd.operandA & cmd.operandB;
            LogicOr:         singleResult = cmd.operandA | cmd.operandB;
            LogicXor:        singleResult = cmd.operandA ^ cmd.operandB;
            LogicXnor:       singleResult = cmd.operandA ~^ cmd.operandB;
            default:         singleResult = '0;  // Unknown codes give zero
        endcase
    end

    always_ff @(posedge i_clock or posedge i_startSignal) begin
        if (i_startSignal) begin
            busy          <= 1'b0;
            o_resultValid <= 1'b0;
        end else begin
            o_resultValid <= (cmd.start && !divStart && !sqrtStart) || unitDone;
            if (divStart || sqrtStart) busy <= 1'b1;
            else if (unitDone) busy <= 1'b0;
        end
    end

    // Result capture
    always_ff @(posedge i_clock) begin
        if (cmd.start) begin
            pendingOp    <= cmd.opcode;
            o_resultWord <= singleResult;
            o_divByZero  <= 1'b0;
        end else if (busy && divDone) begin
            o_resultWord <= (pendingOp == IntMod) ? divRemainder : divQuotient;
            o_divByZero  <= divZero;
        end else if (busy && sqrtDone) begin
            o_resultWord <= {{(DataWidth - DataWidth/2){1'b0}}, sqrtRoot};
            o_divByZero  <= 1'b0;  // Sqrt clears a stale flag
        end
    end

    intDivider #(.Width(DataWidth)) divider0 (
        .i_clock      (i_clock),
        .i_startSignal(i_startSignal),
        .i_start      (divStart),
        .i_dividend   (cmd.operandA),
        .i_divisor    (cmd.operandB),
        .o_done       (divDone),
        .o_quotient   (divQuotient),
        .o_remainder  (divRemainder),
        .o_divByZero  (divZero)
    );

    intSqrt #(.Width(DataWidth)) sqrt0 (
        .i_clock      (i_clock),
        .i_startSignal(i_startSignal),
        .i_start      (sqrtStart),
        .i_radicand   (cmd.operandA),
        .o_done       (sqrtDone),
        .o_root       (sqrtRoot)
    );

endmodule

`default_nettype wire

//--- resultPort.sv
`timescale 1ns/10ps
`default_nettype none

module resultPort import aluPkg::*; #(
    parameter int DataWidth = aluPkg::DataWidth
) (
    input  wire                  i_clock,
    input  wire                  i_startSignal,
    input  wire                  i_resultValid,
    input  wire  [DataWidth-1:0] i_resultWord,
    input  wire                  i_divByZero,
    output logic                 o_done,
    output logic [DataWidth-1:0] o_result,
    output aluStatus_t           o_status
);

    logic isZero;

    assign isZero = (i_resultWord == '0);

    // Holds the last result until the next one arrives
    always_ff @(posedge i_clock or posedge i_startSignal) begin
        if (i_startSignal) begin
            o_done   <= 1'b0;
            o_result <= '0;
            o_status <= '0;
        end else begin
            o_done <= i_resultValid;  // One pulse per captured result
            if (i_resultValid) begin
                o_result            <= i_resultWord;
                o_status.divByZero  <= i_divByZero;
                o_status.zeroResult <= isZero;
            end
        end
    end

endmodule

`default_nettype wire

//--- aluTop.sv
`timescale 1ns/10ps
`default_nettype none

module aluTop import aluPkg::*; #(
    parameter int DataWidth = aluPkg::DataWidth
) (
    input  wire                  Clock,
    input  wire                  StartSignal,
    input  wire                  i_wbCyc,
    input  wire                  i_wbStb,
    input  wire                  i_wbWe,
    input  wire aluReg_t         i_wbAdr,
    input  wire  [DataWidth-1:0] i_wbDat,
    output logic [DataWidth-1:0] o_wbDat,
    output logic                 o_wbAck
);

    logic                 resultValid;
    logic [DataWidth-1:0] resultWord;
    logic                 divByZero;
    logic                 done;
    logic [DataWidth-1:0] result;
    aluStatus_t           status;

    aluCmdIf cmdBus ();  // Command path from bus port to core

    wbCmdPort #(.DataWidth(DataWidth)) cmdPort0 (
        .i_clock      (Clock),
        .i_startSignal(StartSignal),
        .i_wbCyc      (i_wbCyc),
        .i_wbStb      (i_wbStb),
        .i_wbWe       (i_wbWe),
        .i_wbAdr      (i_wbAdr),
        .i_wbDat      (i_wbDat),
        .o_wbDat      (o_wbDat),
        .o_wbAck      (o_wbAck),
        .i_done       (done),
        .i_result     (result),
        .i_status     (status),
        .cmd          (cmdBus.issuer)
    );

    aluCore #(.DataWidth(DataWidth)) core0 (
        .cmd          (cmdBus.core),
        .i_clock      (Clock),
        .i_startSignal(StartSignal),
        .o_resultValid(resultValid),
        .o_resultWord (resultWord),
        .o_divByZero  (divByZero)
    );

    resultPort #(.DataWidth(DataWidth)) resultPort0 (
        .i_clock      (Clock),
        .i_startSignal(StartSignal),
        .i_resultValid(resultValid),
        .i_resultWord (resultWord),
        .i_divByZero  (divByZero),
        .o_done       (done),
        .o_result     (result),
        .o_status     (status)
    );

endmodule

`default_nettype wire

//--- aluTop_chk.sv
`timescale 1ns/10ps
`default_nettype none

module aluTop_chk import aluPkg::*; #(
    parameter int DataWidth = aluPkg::DataWidth
) (
    input wire                 Clock,
    input wire                 StartSignal,
    input wire                 i_wbCyc,
    input wire                 i_wbStb,
    input wire                 o_wbAck,
    input wire [DataWidth-1:0] o_wbDat
);

    // Ack only for a strobe already seen in the cycle before
    ackInStrobe: assert property (@(posedge Clock) disable iff (StartSignal)
        o_wbAck |-> (i_wbCyc && i_wbStb && $past(i_wbCyc && i_wbStb)))
        else $error("ack seen outside a cyc and stb that started a cycle earlier");

    // Ack gone by the cycle after the strobe ends
    ackFollowsStrobe: assert property (@(posedge Clock) disable iff (StartSignal)
        $fell(i_wbStb) |=> !o_wbAck)
        else $error("ack still high one cycle after stb fell");

    readDataKnown: assert property (@(posedge Clock) disable iff (StartSignal)
        o_wbAck |-> !$isunknown(o_wbDat))
        else $error("read data has X bits during ack");

endmodule

bind aluTop aluTop_chk #(.DataWidth(DataWidth)) chk0 (
    .Clock      (Clock),
    .StartSignal(StartSignal),
    .i_wbCyc    (i_wbCyc),
    .i_wbStb    (i_wbStb),
    .o_wbAck    (o_wbAck),
    .o_wbDat    (o_wbDat)
);

`default_nettype wire

//--- aluTb.sv
`timescale 1ns/10ps
`default_nettype none

module aluTb import aluPkg::*; ();

    localparam int ClockPeriod = 20;
    localparam int ResetCycles = 4;
    localparam int NumCorners  = 5;
    localparam int PairsPerOp  = 9;   // Corner pairs, then random ones
    localparam int DivRandom   = 8;
    localparam int SqrtRandom  = 6;

    localparam aluOp_t SingleOpList[18] = '{
        IntAdd, IntSub, IntMul, ShiftLeftArith, ShiftRightArith, ShiftLeftLogic,
        ShiftRightLogic, CmpEq, CmpNe, CmpGt, CmpLt, CmpGtu, CmpLtu,
        LogicNot, LogicAnd, LogicOr, LogicXor, LogicXnor
    };
    localparam aluWord_t CornerA[NumCorners] = '{
        32'h0000_0000, 32'h0000_0001, 32'h8000_0000, 32'hFFFF_FFFF, 32'h1234_5678
    };
    localparam aluWord_t CornerB[NumCorners] = '{
        32'h0000_0000, 32'hFFFF_FFFF, 32'h7FFF_FFFF, 32'h0000_001F, 32'h0000_0024
    };

    // Operation count of all test groups for the watchdog
    localparam int NumOps = 3 + 18 * PairsPerOp + (10 + 2 * DivRandom) + 4
                          + (9 + SqrtRandom) + 4;
    localparam int WatchdogTime = NumOps * 60 * ClockPeriod * 2;

    logic     Clock;
    logic     StartSignal;
    logic     wbCyc;
    logic     wbStb;
    logic     wbWe;
    aluReg_t  wbAdr;
    aluWord_t wbDat;
    aluWord_t rdDat;
    logic     wbAck;
    int       opsDone;

    aluTop #(.DataWidth(DataWidth)) dut0 (
        .Clock      (Clock),
        .StartSignal(StartSignal),
        .i_wbCyc    (wbCyc),
        .i_wbStb    (wbStb),
        .i_wbWe     (wbWe),
        .i_wbAdr    (wbAdr),
        .i_wbDat    (wbDat),
        .o_wbDat    (rdDat),
        .o_wbAck    (wbAck)
    );

    initial begin
        Clock = 1'b0;
        forever #(ClockPeriod / 2) Clock = ~Clock;
    end

    task automatic stopRun();
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    initial begin
        #(WatchdogTime);
        $display("Timeout: the tests were still running after %0d ns", WatchdogTime);
        stopRun();
    end

    // Floor of the square root by bisection
    function automatic aluWord_t floorRoot(input aluWord_t value);
        longint lo;
        longint hi;
        longint mid;
        lo = 0;
        hi = 65536;
        while (hi - lo > 1) begin
            mid = (lo + hi) / 2;
            if (mid * mid <= longint'(value)) lo = mid;
            else hi = mid;
        end
        return aluWord_t'(lo);
    endfunction

    function automatic aluWord_t modelResult(input logic [5:0] code, input aluWord_t a,
                                             input aluWord_t b);
        int          sa;
        int          sb;
        int unsigned amount;
        logic [63:0] product;
        longint      quo;
        longint      rem;
        sa      = a;
        sb      = b;
        amount  = b[4:0];
        product = {32'b0, a} * {32'b0, b};
        if (sb == 0) begin
            quo = -1;            // All ones
            rem = longint'(sa);
        end else begin
            quo = longint'(sa) / longint'(sb);  // Wide enough for min / -1 to wrap to min
            rem = longint'(sa) % longint'(sb);
        end
        case (code)
            IntAdd:          return a + b;
            IntSub:          return a - b;
            IntMul:          return product[31:0];
            IntSqrt:         return floorRoot(a);
            IntDiv:          return aluWord_t'(quo);
            IntMod:          return aluWord_t'(rem);
            ShiftLeftArith,
            ShiftLeftLogic:  return a << amount;
            ShiftRightArith: return aluWord_t'(sa >>> amount);
            ShiftRightLogic: return a >> amount;
            CmpEq:           return aluWord_t'(a == b);
            CmpNe:           return aluWord_t'(a != b);
            CmpGt:           return aluWord_t'(sa > sb);
            CmpLt:           return aluWord_t'(sa < sb);
            CmpGtu:          return aluWord_t'(a > b);
            CmpLtu:          return aluWord_t'(a < b);
            LogicNot:        return ~a;
            LogicAnd:        return a & b;
            LogicOr:         return a | b;
            LogicXor:        return a ^ b;
            LogicXnor:       return ~(a ^ b);
            default:         return '0;
        endcase
    endfunction

    function automatic aluStatus_t modelStatus(input logic [5:0] code, input aluWord_t b,
                                               input aluWord_t res);
        aluStatus_t st;
        st.divByZero  = (code == IntDiv || code == IntMod) && (b == '0);
        st.zeroResult = (res == '0);
        return st;
    endfunction

    task automatic checkResult(input string name, input aluWord_t got, input aluWord_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
            stopRun();
        end
    endtask

    task automatic checkStatus(input string name, input aluStatus_t got,
                               input aluStatus_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
            stopRun();
        end
    endtask

    // One classic cycle with the strobe held until the ack
    task automatic busCycle(input logic we, input aluReg_t adr, input aluWord_t data,
                            output aluWord_t readData, output int waitCycles);
        @(negedge Clock);
        wbCyc      = 1'b1;
        wbStb      = 1'b1;
        wbWe       = we;
        wbAdr      = adr;
        wbDat      = data;
        waitCycles = 0;
        do begin
            @(negedge Clock);
            waitCycles++;
        end while (!wbAck);
        readData = rdDat;
        @(negedge Clock);
        if (!wbAck) begin
            $display("Error: ack dropped at %0t while the strobe was still high", $time);
            stopRun();
        end
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
    endtask

    task automatic wbWrite(input aluReg_t adr, input aluWord_t data, output int waitCycles);
        aluWord_t unused;
        busCycle(1'b1, adr, data, unused, waitCycles);
    endtask

    task automatic wbRead(input aluReg_t adr, output aluWord_t data);
        int waitCycles;
        busCycle(1'b0, adr, '0, data, waitCycles);
    endtask

    task automatic runOp(input logic [5:0] code, input aluWord_t a, input aluWord_t b);
        aluWord_t expResult;
        aluWord_t gotResult;
        aluWord_t statusWord;
        int       waitCycles;
        expResult = modelResult(code, a, b);
        wbWrite(RegOperandA, a, waitCycles);
        wbWrite(RegOperandB, b, waitCycles);
        wbWrite(RegCommand, aluWord_t'(code), waitCycles);
        // Issue, result, capture, then ack
        if (waitCycles < 4) begin
            $display("Error: command %0d was acked after %0d cycles, before its result was stored",
                     code, waitCycles);
            stopRun();
        end
        wbRead(RegResult, gotResult);
        wbRead(RegCommand, statusWord);
        checkResult($sformatf("o_wbDat (result, op %0d)", code), gotResult, expResult);
        checkStatus($sformatf("o_wbDat[1:0] (status, op %0d)", code),
                    aluStatus_t'(statusWord[1:0]), modelStatus(code, b, expResult));
        opsDone++;
    endtask

    task automatic operandReadBack();
        aluWord_t valueA;
        aluWord_t valueB;
        aluWord_t readBack;
        int       waitCycles;
        for (int i = 0; i < 3; i++) begin
            valueA = (i == 0) ? 32'hFFFF_FFFF : $urandom;
            valueB = (i == 0) ? 32'h0000_0000 : $urandom;
            wbWrite(RegOperandA, valueA, waitCycles);
            wbWrite(RegOperandB, valueB, waitCycles);
            wbRead(RegOperandA, readBack);
            checkResult("o_wbDat (operand A)", readBack, valueA);
            wbRead(RegOperandB, readBack);
            checkResult("o_wbDat (operand B)", readBack, valueB);
        end
    endtask

    task automatic singleCycleOps();
        aluWord_t a;
        aluWord_t b;
        foreach (SingleOpList[op]) begin
            for (int p = 0; p < PairsPerOp; p++) begin
                if (p < NumCorners) begin
                    a = CornerA[p];
                    b = CornerB[p];
                end else begin
                    a = $urandom;
                    b = $urandom;
                end
                runOp(SingleOpList[op], a, b);
            end
        end
    endtask

    task automatic divPair(input aluWord_t a, input aluWord_t b);
        runOp(IntDiv, a, b);
        runOp(IntMod, a, b);
    endtask

    task automatic signedDivide();
        aluWord_t a;
        aluWord_t b;
        divPair(32'd100, 32'd7);       // All four sign pairs
        divPair(aluWord_t'(-100), 32'd7);
        divPair(32'd100, aluWord_t'(-7));
        divPair(aluWord_t'(-100), aluWord_t'(-7));
        for (int i = 0; i < DivRandom; i++) begin
            a = $urandom;
            b = $urandom >> ($urandom % 32);  // Spread the divisor sizes
            if (b == '0) b = 32'd3;
            divPair(a, b);
        end
        divPair(32'h8000_0000, 32'hFFFF_FFFF);
    endtask

    task automatic divideByZero();
        divPair(32'd12345, 32'd0);
        divPair(32'h8000_0001, 32'd0);  // Negative dividend kept as remainder
    endtask

    task automatic squareRoots();
        runOp(IntSqrt, 32'd0, 32'd0);
        runOp(IntSqrt, 32'd1, 32'd0);
        runOp(IntSqrt, 32'd4, 32'd0);
        runOp(IntSqrt, 32'd144, 32'd0);
        runOp(IntSqrt, 32'hFFFE_0001, 32'd0);  // 65535 squared
        runOp(IntSqrt, 32'hFFFF_FFFF, 32'd0);
        runOp(IntSqrt, 32'd143, 32'd0);
        for (int i = 0; i < SqrtRandom; i++) begin
            runOp(IntSqrt, $urandom, $urandom);
        end
        // Stale divide-by-zero flag must clear
        runOp(IntDiv, 32'd5, 32'd0);
        runOp(IntSqrt, 32'd49, 32'd0);
    endtask

    task automatic unknownOpcodes();
        runOp(6'd14, $urandom, $urandom);
        runOp(6'd15, $urandom, $urandom);
        runOp(6'd21, $urandom, $urandom);
        runOp(6'd63, $urandom, $urandom);
    endtask

    initial begin
        void'($urandom(3));
        opsDone     = 0;
        StartSignal = 1'b1;
        wbCyc       = 1'b0;
        wbStb       = 1'b0;
        wbWe        = 1'b0;
        wbAdr       = RegOperandA;
        wbDat       = '0;
        repeat (ResetCycles) @(posedge Clock);
        @(negedge Clock);
        StartSignal = 1'b0;

        operandReadBack();
        singleCycleOps();
        signedDivide();
        divideByZero();
        squareRoots();
        unknownOpcodes();

        $display("Checked %0d operations", opsDone);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
aluPkg.sv
aluCmdIf.sv
intDivider.sv
intSqrt.sv
wbCmdPort.sv
aluCore.sv
resultPort.sv
aluTop.sv
aluTop_chk.sv
aluTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= aluTb
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SOURCES := $(wildcard *.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '** FAIL **' $(LOG) || ! grep -qF '** PASS **' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
